//--- Makefile
# Verilator build for the SDRAM controller testbench.
TOP     ?= sdramCtrlTb
POWERUP ?=
VFLAGS  ?= --binary --timing --assert -j 0
FLIST   ?= sdramCtrl.f
OBJDIR  ?= obj_dir

ifneq ($(POWERUP),)
DEFS := +define+SDRAM_POWERUP=$(POWERUP)
endif

.PHONY: help test clean

help:
	@echo "make test   build and run the testbench, fail unless it passes"
	@echo "make clean  remove build output"
	@echo "variables:  TOP POWERUP VFLAGS"

test:
	verilator $(VFLAGS) $(DEFS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf $(OBJDIR)

//--- bench/sdramCtrlTb.sv
`timescale 1ns/100ps
`include "sdramCtrl_cfg.svh"

module sdramCtrlTb;

    // Worst-case cycles per operation plus a little slack.
    localparam int INIT_LAT = 2 + `SDRAM_TRP + 2 * `SDRAM_TRC + `SDRAM_TMRD + 6;
    localparam int REF_LAT  = 2 + `SDRAM_TRP + 2 * `SDRAM_TRC + 6;
    localparam int WR_LAT   = 2 + `SDRAM_TRCD + `SDRAM_BURST + `SDRAM_TWR + `SDRAM_TRP + 6;
    localparam int RD_LAT   = 2 + `SDRAM_TRCD + `SDRAM_CL + `SDRAM_BURST + `SDRAM_TRP + 6;
    localparam int HOLD     = 20;
    localparam int LIMIT    = 3 * (10 + INIT_LAT + REF_LAT + HOLD + 7 * (WR_LAT + RD_LAT)) / 2
                              + `SDRAM_POWERUP;

    logic                 clk;
    logic                 rst_n;
    logic [3:0]           req;
    sdramPkg::sdramAddr_t addr;
    sdramPkg::sdramWord_t wrData1, wrData2, wrData3, wrData4;
    sdramPkg::sdramWord_t rdData1, rdData2, rdData3, rdData4;
    logic                 done;
    logic                 sdCke, sdCsN, sdRasN, sdCasN, sdWeN;
    logic [1:0]           sdBa;
    logic [12:0]          sdA;
    wire  [15:0]          sdDq;
    logic [4:0]           pinCmd;

    logic [15:0] lfsr = 16'd55;
    int          cyc = 0;
    int          monErrs = 0;
    int          seqErrs = 0;
    int          propErrs = 0;
    int          doneCount = 0;
    int          cmdTotal = 0;
    logic [4:0]  cmdLog [256];
    logic [4:0]  expSeq [$];
    logic [4:0]  lastCmd = 5'(sdramPkg::CMD_NOP);
    int          lastCyc = 0;
    int          actCyc = 0;
    logic        refreshing;
    logic [23:0] curAddr;
    logic [15:0] words [4];

    tbClock tbClock_i (.clk(clk), .rst_n(rst_n));

    tbSdramModel tbSdramModel_i (
        .clk(clk), .cke(sdCke), .csN(sdCsN), .rasN(sdRasN), .casN(sdCasN), .weN(sdWeN),
        .ba(sdBa), .a(sdA), .dq(sdDq)
    );

    sdramCtrl sdramCtrl_i (
        .clk(clk), .rst_n(rst_n), .req(req), .addr(addr),
        .wrData1(wrData1), .wrData2(wrData2), .wrData3(wrData3), .wrData4(wrData4),
        .done(done), .rdData1(rdData1), .rdData2(rdData2), .rdData3(rdData3), .rdData4(rdData4),
        .sdCke(sdCke), .sdCsN(sdCsN), .sdRasN(sdRasN), .sdCasN(sdCasN), .sdWeN(sdWeN),
        .sdBa(sdBa), .sdA(sdA), .sdDq(sdDq)
    );

    assign pinCmd = {sdCke, sdCsN, sdRasN, sdCasN, sdWeN};

    // Galois LFSR stepped once per bit.
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        logic        b;
        v = '0;
        for (int i = 0; i < n; i++) begin
            b    = lfsr[0];
            lfsr = lfsr >> 1;
            if (b) lfsr = lfsr ^ 16'hB400;
            v = {v[30:0], b};
        end
        return v;
    endfunction

    function automatic bit sameVal(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        if (act !== exp) begin
            $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
        return act === exp;
    endfunction

    function automatic bit holds(input bit cond, input string msg);
        if (!cond) $display("ERROR at %0t: %s", $time, msg);
        return cond;
    endfunction

    doneSingle: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else begin
            propErrs++;
            $display("ERROR at %0t: done stayed high for more than one cycle", $time);
        end

    always @(posedge clk) cyc <= cyc + 1;

    initial begin
        wait (cyc >= LIMIT);
        $display("Timeout after %0d cycles, an operation never finished", cyc);
        $display("Regression failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pin monitor. Logs commands and checks gaps and addresses.
    ////////////////////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        if (rst_n) begin
            if (done) doneCount <= doneCount + 1;
            if (refreshing) assert (sameVal("dqOe", 0, sdramCtrl_i.dqOe)) else monErrs++;
            if (pinCmd != 5'(sdramPkg::CMD_NOP)) begin
                cmdLog[cmdTotal] <= pinCmd;
                cmdTotal <= cmdTotal + 1;
                lastCmd  <= pinCmd;
                lastCyc  <= cyc;
                case (pinCmd)
                    5'(sdramPkg::CMD_ACT): begin
                        actCyc <= cyc;
                        assert (sameVal("sdBa", curAddr[23:22], sdBa)) else monErrs++;
                        assert (sameVal("sdA row", curAddr[21:9], sdA)) else monErrs++;
                    end
                    5'(sdramPkg::CMD_WR), 5'(sdramPkg::CMD_RD): begin
                        assert (sameVal("ACT to RW gap", `SDRAM_TRCD, cyc - actCyc))
                            else monErrs++;
                        assert (sameVal("sdBa", curAddr[23:22], sdBa)) else monErrs++;
                        assert (sameVal("sdA column", {4'b0010, curAddr[8:0]}, sdA))
                            else monErrs++;
                    end
                    5'(sdramPkg::CMD_AR): begin
                        if (lastCmd == 5'(sdramPkg::CMD_PR)) begin
                            assert (sameVal("PR to AR gap", `SDRAM_TRP, cyc - lastCyc))
                                else monErrs++;
                        end else begin
                            assert (sameVal("AR to AR gap", `SDRAM_TRC, cyc - lastCyc))
                                else monErrs++;
                        end
                    end
                    5'(sdramPkg::CMD_LMR): begin
                        assert (sameVal("AR to LMR gap", `SDRAM_TRC, cyc - lastCyc))
                            else monErrs++;
                        assert (sameVal("sdA mode", `SDRAM_MODE_WORD, sdA)) else monErrs++;
                        assert (sameVal("sdBa mode", 0, sdBa)) else monErrs++;
                    end
                    default: ;
                endcase
            end
        end
    end

    // Entered and left 2 ns after a rising edge.
    task automatic runOp(input logic [3:0] bits, input int holdCycles);
        int snapDone;
        int snapCmd;
        snapDone = doneCount;
        req = bits;
        do @(posedge clk); while (!done);
        #2;
        if (holdCycles > 0) begin
            snapCmd = cmdTotal;
            repeat (holdCycles) @(posedge clk);
            #2;
            assert (holds(cmdTotal == snapCmd,
                          "a second operation started while the request was held"))
                else seqErrs++;
        end
        req = 4'b0000;
        repeat (2) @(posedge clk);
        #2;
        assert (holds(doneCount == snapDone + 1, "done did not pulse exactly once"))
            else seqErrs++;
    endtask

    task automatic checkCmds(input int start);
        assert (sameVal("command count", expSeq.size(), cmdTotal - start)) else seqErrs++;
        for (int k = 0; k < expSeq.size() && start + k < cmdTotal; k++) begin
            assert (sameVal("command", expSeq[k], cmdLog[start + k])) else seqErrs++;
        end
    endtask

    // Write four words to addr, then read them back.
    task automatic writeThenRead(input logic [3:0] wrReq);
        int start;
        for (int w = 0; w < 4; w++) words[w] = 16'(randBits(16));
        curAddr = addr;
        wrData1 = words[0];
        wrData2 = words[1];
        wrData3 = words[2];
        wrData4 = words[3];
        start = cmdTotal;
        runOp(wrReq, 0);
        expSeq = {5'(sdramPkg::CMD_ACT), 5'(sdramPkg::CMD_WR)};
        checkCmds(start);
        start = cmdTotal;
        runOp(4'b0100, 0);
        expSeq = {5'(sdramPkg::CMD_ACT), 5'(sdramPkg::CMD_RD)};
        checkCmds(start);
        assert (sameVal("rdData1", words[0], rdData1)) else seqErrs++;
        assert (sameVal("rdData2", words[1], rdData2)) else seqErrs++;
        assert (sameVal("rdData3", words[2], rdData3)) else seqErrs++;
        assert (sameVal("rdData4", words[3], rdData4)) else seqErrs++;
    endtask

    initial begin
        int start;
        req        = 4'b0000;
        addr       = '0;
        wrData1    = '0;
        wrData2    = '0;
        wrData3    = '0;
        wrData4    = '0;
        refreshing = 1'b0;
        curAddr    = '0;
        @(posedge rst_n);
        repeat (3) begin                        // Idle state after reset.
            @(posedge clk);
            assert (sameVal("done", 0, done)) else seqErrs++;
            assert (sameVal("command", 5'(sdramPkg::CMD_NOP), pinCmd)) else seqErrs++;
            assert (sameVal("dqOe", 0, sdramCtrl_i.dqOe)) else seqErrs++;
            assert (sameVal("sdBa", 2'b11, sdBa)) else seqErrs++;
            assert (sameVal("sdA", 13'h1FFF, sdA)) else seqErrs++;
        end
        #2;
        start = cmdTotal;
        runOp(4'b0001, 0);
        expSeq = {5'(sdramPkg::CMD_PR), 5'(sdramPkg::CMD_AR), 5'(sdramPkg::CMD_AR),
                  5'(sdramPkg::CMD_LMR)};
        checkCmds(start);
        // Refresh with the request held well past done.
        refreshing = 1'b1;
        start = cmdTotal;
        runOp(4'b0010, HOLD);
        refreshing = 1'b0;
        expSeq = {5'(sdramPkg::CMD_PR), 5'(sdramPkg::CMD_AR), 5'(sdramPkg::CMD_AR)};
        checkCmds(start);
        for (int i = 0; i < 6; i++) begin
            if (i == 3) addr = {addr[23:9], addr[8:0] ^ 9'h010};   // Same row with a new column.
            else addr = 24'(randBits(24));
            writeThenRead(4'b1000);
        end
        addr = 24'(randBits(24));
        writeThenRead(4'b1100);                 // Write wins over read.
        $display("Errors: monitor %0d, sequence %0d, property %0d", monErrs, seqErrs, propErrs);
        if (monErrs + seqErrs + propErrs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- bench/tbClock.sv
`timescale 1ns/100ps

module tbClock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                 // 20 ns period.
    end

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);              // Two cycles in reset.
        #2 rst_n = 1'b1;
    end

endmodule

//--- bench/tbSdramModel.sv
`timescale 1ns/100ps
`include "sdramCtrl_cfg.svh"

module tbSdramModel (
    input  logic        clk,
    input  logic        cke,
    input  logic        csN,
    input  logic        rasN,
    input  logic        casN,
    input  logic        weN,
    input  logic [1:0]  ba,
    input  logic [12:0] a,
    inout  wire  [15:0] dq
);

    logic [12:0] openRow [4];                   // Row opened per bank.
    logic [15:0] mem [logic [23:0]];            // Only written words exist.
    logic [23:0] wrBase;
    logic [23:0] rdBase;
    int          wrBeat = 0;
    int          rdTimer = 0;                   // Edges since RD was seen.
    logic [15:0] rdWord;
    logic [4:0]  pinCmd;

    // Sequential burst wraps inside a four-word block.
    function automatic logic [23:0] burstKey(input logic [23:0] base, input logic [1:0] beat);
        return {base[23:2], base[1:0] + beat};
    endfunction

    assign pinCmd = {cke, csN, rasN, casN, weN};

    always_comb begin
        rdWord = 16'h0000;
        if (mem.exists(burstKey(rdBase, 2'(rdTimer - `SDRAM_CL)))) begin
            rdWord = mem[burstKey(rdBase, 2'(rdTimer - `SDRAM_CL))];
        end
    end

    // Word k is on DQ during the cycle before edge RD + CL + k.
    assign dq = (rdTimer >= `SDRAM_CL && rdTimer < `SDRAM_CL + `SDRAM_BURST) ? rdWord : 'z;

    always @(posedge clk) begin
        if (wrBeat > 0) begin
            mem[burstKey(wrBase, 2'(wrBeat))] = dq;
            wrBeat <= (wrBeat == `SDRAM_BURST - 1) ? 0 : wrBeat + 1;
        end
        if (rdTimer == `SDRAM_CL + `SDRAM_BURST - 1) rdTimer <= 0;
        else if (rdTimer > 0) rdTimer <= rdTimer + 1;
        if (pinCmd == 5'(sdramPkg::CMD_ACT)) begin
            openRow[ba] <= a;
        end else if (pinCmd == 5'(sdramPkg::CMD_WR)) begin
            wrBase <= {ba, openRow[ba], a[8:0]};
            mem[burstKey({ba, openRow[ba], a[8:0]}, 2'd0)] = dq;    // Word 1 meets WR.
            wrBeat <= 1;
        end else if (pinCmd == 5'(sdramPkg::CMD_RD)) begin
            rdBase  <= {ba, openRow[ba], a[8:0]};
            rdTimer <= 1;
        end
    end

endmodule

//--- sdramCtrl.f
+incdir+src
src/sdramPkg.sv
src/sdramOpSequencer.sv
src/sdramPinDriver.sv
src/sdramDataPath.sv
src/sdramCtrl.sv
bench/tbClock.sv
bench/tbSdramModel.sv
bench/sdramCtrlTb.sv

//--- src/sdramCtrl.sv
`timescale 1ns/100ps
`include "sdramCtrl_cfg.svh"

module sdramCtrl (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [3:0]                req,      // Write, read, refresh, init.
    input  sdramPkg::sdramAddr_t      addr,
    input  sdramPkg::sdramWord_t      wrData1,
    input  sdramPkg::sdramWord_t      wrData2,
    input  sdramPkg::sdramWord_t      wrData3,
    input  sdramPkg::sdramWord_t      wrData4,
    output logic                      done,
    output sdramPkg::sdramWord_t      rdData1,
    output sdramPkg::sdramWord_t      rdData2,
    output sdramPkg::sdramWord_t      rdData3,
    output sdramPkg::sdramWord_t      rdData4,
    output logic                      sdCke,
    output logic                      sdCsN,
    output logic                      sdRasN,
    output logic                      sdCasN,
    output logic                      sdWeN,
    output logic [`SDRAM_BANK_W-1:0]  sdBa,
    output logic [`SDRAM_ROW_W-1:0]   sdA,
    inout  wire  [`SDRAM_DQ_W-1:0]    sdDq
);

    logic                    cmdValid;
    sdramPkg::sdramCmd_u     cmd;
    sdramPkg::sdramAddrSel_e addrSel;
    logic                    wrLoad;
    logic                    rdCapture;
    logic                    busWrite;
    sdramPkg::sdramWord_t    dqOut;
    logic                    dqOe;

    // Released unless a write burst is on the bus.
    assign sdDq = dqOe ? dqOut : 'z;

    sdramOpSequencer sdramOpSequencer_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .cmdValid  (cmdValid),
        .cmd       (cmd),
        .addrSel   (addrSel),
        .wrLoad    (wrLoad),
        .rdCapture (rdCapture),
        .busWrite  (busWrite),
        .done      (done)
    );

    sdramPinDriver sdramPinDriver_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .cmdValid (cmdValid),
        .cmd      (cmd),
        .addrSel  (addrSel),
        .addr     (addr),
        .sdCke    (sdCke),
        .sdCsN    (sdCsN),
        .sdRasN   (sdRasN),
        .sdCasN   (sdCasN),
        .sdWeN    (sdWeN),
        .sdBa     (sdBa),
        .sdA      (sdA)
    );

    sdramDataPath sdramDataPath_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .wrLoad    (wrLoad),
        .rdCapture (rdCapture),
        .busWrite  (busWrite),
        .wrData1   (wrData1),
        .wrData2   (wrData2),
        .wrData3   (wrData3),
        .wrData4   (wrData4),
        .dqIn      (sdDq),
        .dqOut     (dqOut),
        .dqOe      (dqOe),
        .rdData1   (rdData1),
        .rdData2   (rdData2),
        .rdData3   (rdData3),
        .rdData4   (rdData4)
    );

endmodule

//--- src/sdramCtrl_cfg.svh
`ifndef SDRAMCTRL_CFG_SVH
`define SDRAMCTRL_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// Datasheet gaps in clock cycles at 133 MHz.
////////////////////////////////////////////////////////////////////////////
`define SDRAM_TRP 3        // Precharge to next command, 20 ns.
`define SDRAM_TRC 9        // Refresh to refresh, 63 ns.
`define SDRAM_TRCD 3       // Activate to read or write, 20 ns.
`define SDRAM_TMRD 2       // Mode register load to next command.
`define SDRAM_TWR 2        // Last write word to precharge.
`define SDRAM_CL 3         // CAS latency.
`define SDRAM_POWERUP 13300 // About 100 us of NOP after power-up.
`define SDRAM_BURST 4      // Words per burst.

////////////////////////////////////////////////////////////////////////////
// Address and data widths.
////////////////////////////////////////////////////////////////////////////
`define SDRAM_BANK_W 2
`define SDRAM_ROW_W 13
`define SDRAM_COL_W 9
`define SDRAM_DQ_W 16

// Burst write, CL 3 on A6..A4, sequential, burst length 4 on A2..A0.
`define SDRAM_MODE_WORD 13'h0032

`endif

//--- src/sdramDataPath.sv
`timescale 1ns/100ps
`include "sdramCtrl_cfg.svh"

module sdramDataPath (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 wrLoad,
    input  logic                 rdCapture,
    input  logic                 busWrite,
    input  sdramPkg::sdramWord_t wrData1,
    input  sdramPkg::sdramWord_t wrData2,
    input  sdramPkg::sdramWord_t wrData3,
    input  sdramPkg::sdramWord_t wrData4,
    input  sdramPkg::sdramWord_t dqIn,
    output sdramPkg::sdramWord_t dqOut,
    output logic                 dqOe,
    output sdramPkg::sdramWord_t rdData1,
    output sdramPkg::sdramWord_t rdData2,
    output sdramPkg::sdramWord_t rdData3,
    output sdramPkg::sdramWord_t rdData4
);

    localparam int CNT_W = $clog2(`SDRAM_BURST);

    logic                 wrStart;
    logic                 rdStart;
    logic [CNT_W-1:0]     wrLeft;       // Words still to shift out.
    logic [2:0]           rdSlot;       // One-hot, words 2 to 4.
    sdramPkg::sdramWord_t wrQueue [3];

    assign wrStart = wrLoad && busWrite;
    assign rdStart = rdCapture && !busWrite;

    ////////////////////////////////////////////////////////////////////////////
    // Burst control.
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dqOe   <= 1'b0;                     // DQ released.
            wrLeft <= '0;
            rdSlot <= '0;
        end else begin
            if (wrStart) begin
                dqOe   <= 1'b1;
                wrLeft <= CNT_W'(`SDRAM_BURST - 1);
            end else if (wrLeft != '0) begin
                wrLeft <= wrLeft - 1'b1;
            end else begin
                dqOe <= 1'b0;                   // After the fourth word.
            end
            rdSlot <= rdStart ? 3'b001 : {rdSlot[1:0], 1'b0};
        end
    end

    // Write words and read captures.
    always_ff @(posedge clk) begin
        if (wrStart) begin
            dqOut      <= wrData1;
            wrQueue[0] <= wrData2;
            wrQueue[1] <= wrData3;
            wrQueue[2] <= wrData4;
        end else if (wrLeft != '0) begin
            dqOut      <= wrQueue[0];
            wrQueue[0] <= wrQueue[1];
            wrQueue[1] <= wrQueue[2];
        end
        if (rdStart) rdData1 <= dqIn;
        if (rdSlot[0]) rdData2 <= dqIn;
        if (rdSlot[1]) rdData3 <= dqIn;
        if (rdSlot[2]) rdData4 <= dqIn;
    end

endmodule

//--- src/sdramOpSequencer.sv
`timescale 1ns/100ps
`include "sdramCtrl_cfg.svh"

module sdramOpSequencer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [3:0]                req,
    output logic                      cmdValid,
    output sdramPkg::sdramCmd_u       cmd,
    output sdramPkg::sdramAddrSel_e   addrSel,
    output logic                      wrLoad,
    output logic                      rdCapture,
    output logic                      busWrite,
    output logic                      done
);

    // Wide enough for the power-up wait and every other gap.
    localparam int WAIT_W = $clog2(`SDRAM_POWERUP + `SDRAM_TRC + `SDRAM_BURST + 1);

    localparam logic [1:0] PH_IDLE = 2'd0; // Waiting for a request.
    localparam logic [1:0] PH_BUSY = 2'd1; // Stepping through a command list.
    localparam logic [1:0] PH_HOLD = 2'd2; // Done given, waiting for req to drop.

    logic [1:0]         phase;
    sdramPkg::sdramOp_e op;
    logic [2:0]         step;
    logic [WAIT_W-1:0]  waitCnt;

    // Strobe one command and set the edges until the next step.
    task automatic issue(input sdramPkg::sdramCmdCode_e code,
                         input sdramPkg::sdramAddrSel_e sel,
                         input int gap);
        cmdValid <= 1'b1;
        cmd.code <= code;
        addrSel  <= sel;
        waitCnt  <= WAIT_W'(gap - 1);
    endtask

    task automatic finish();
        done     <= 1'b1;          // Single-cycle pulse.
        busWrite <= 1'b0;
        phase    <= PH_HOLD;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Step FSM. Each step acts when waitCnt is zero.
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase     <= PH_IDLE;
            op        <= sdramPkg::OP_INIT;
            step      <= '0;
            waitCnt   <= '0;
            cmdValid  <= 1'b0;
            cmd.code  <= sdramPkg::CMD_NOP;
            addrSel   <= sdramPkg::SEL_ROW;
            wrLoad    <= 1'b0;
            rdCapture <= 1'b0;
            busWrite  <= 1'b0;
            done      <= 1'b0;
        end else begin
            cmdValid  <= 1'b0;          // Strobes last one cycle.
            wrLoad    <= 1'b0;
            rdCapture <= 1'b0;
            done      <= 1'b0;
            case (phase)
                PH_IDLE: begin
                    if (|req) begin
                        // Write beats read beats refresh beats init.
                        if (req[3]) begin
                            op <= sdramPkg::OP_WRITE;
                        end else if (req[2]) begin
                            op <= sdramPkg::OP_READ;
                        end else if (req[1]) begin
                            op <= sdramPkg::OP_REFRESH;
                        end else begin
                            op <= sdramPkg::OP_INIT;
                        end
                        busWrite <= req[3];     // Direction for the whole access.
                        step     <= '0;
                        waitCnt  <= '0;
                        phase    <= PH_BUSY;
                    end
                end
                PH_BUSY: begin
                    if (waitCnt != '0) begin
                        waitCnt <= waitCnt - 1'b1;
                    end else begin
                        step <= step + 1'b1;
                        case (op)
                            sdramPkg::OP_WRITE: begin
                                case (step)
                                    3'd0: issue(sdramPkg::CMD_ACT, sdramPkg::SEL_ROW, `SDRAM_TRCD);
                                    3'd1: begin
                                        // Done after the burst, write recovery and precharge.
                                        issue(sdramPkg::CMD_WR, sdramPkg::SEL_COLUMN,
                                              `SDRAM_BURST + `SDRAM_TWR + `SDRAM_TRP);
                                        wrLoad <= 1'b1; // Word 1 meets WR on the pins.
                                    end
                                    default: finish();
                                endcase
                            end
                            sdramPkg::OP_READ: begin
                                case (step)
                                    3'd0: issue(sdramPkg::CMD_ACT, sdramPkg::SEL_ROW, `SDRAM_TRCD);
                                    3'd1: issue(sdramPkg::CMD_RD, sdramPkg::SEL_COLUMN, `SDRAM_CL + 1);
                                    3'd2: begin
                                        rdCapture <= 1'b1;  // Word 1 valid on DQ now.
                                        waitCnt   <= WAIT_W'(`SDRAM_BURST + `SDRAM_TRP - 2);
                                    end
                                    default: finish();
                                endcase
                            end
                            sdramPkg::OP_REFRESH: begin
                                case (step)
                                    3'd0: issue(sdramPkg::CMD_PR, sdramPkg::SEL_PRECHARGE_ALL,
                                                `SDRAM_TRP);
                                    3'd1: issue(sdramPkg::CMD_AR, sdramPkg::SEL_PRECHARGE_ALL,
                                                `SDRAM_TRC);
                                    3'd2: issue(sdramPkg::CMD_AR, sdramPkg::SEL_PRECHARGE_ALL,
                                                `SDRAM_TRC + 1);
                                    default: finish();
                                endcase
                            end
                            default: begin          // Init.
                                case (step)
                                    3'd0: waitCnt <= WAIT_W'(`SDRAM_POWERUP - 1); // NOP only.
                                    3'd1: issue(sdramPkg::CMD_PR, sdramPkg::SEL_PRECHARGE_ALL,
                                                `SDRAM_TRP);
                                    3'd2: issue(sdramPkg::CMD_AR, sdramPkg::SEL_PRECHARGE_ALL,
                                                `SDRAM_TRC);
                                    3'd3: issue(sdramPkg::CMD_AR, sdramPkg::SEL_PRECHARGE_ALL,
                                                `SDRAM_TRC);
                                    3'd4: issue(sdramPkg::CMD_LMR, sdramPkg::SEL_MODE,
                                                `SDRAM_TMRD + 1);
                                    default: finish();
                                endcase
                            end
                        endcase
                    end
                end
                PH_HOLD: begin
                    if (req == 4'b0000) begin
                        phase <= PH_IDLE;       // New request seen one cycle later.
                    end
                end
                default: phase <= PH_IDLE;
            endcase
        end
    end

endmodule

//--- src/sdramPinDriver.sv
`timescale 1ns/100ps
`include "sdramCtrl_cfg.svh"

module sdramPinDriver (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      cmdValid,
    input  sdramPkg::sdramCmd_u       cmd,
    input  sdramPkg::sdramAddrSel_e   addrSel,
    input  sdramPkg::sdramAddr_t      addr,
    output logic                      sdCke,
    output logic                      sdCsN,
    output logic                      sdRasN,
    output logic                      sdCasN,
    output logic                      sdWeN,
    output logic [`SDRAM_BANK_W-1:0]  sdBa,
    output logic [`SDRAM_ROW_W-1:0]   sdA
);

    logic [`SDRAM_BANK_W-1:0] bankField;
    logic [`SDRAM_ROW_W-1:0]  rowField;
    logic [`SDRAM_COL_W-1:0]  colField;
    logic [`SDRAM_ROW_W-1:0]  colAddr;
    sdramPkg::sdramCmd_u      cmdQ;

    assign bankField = addr[$bits(addr)-1 -: `SDRAM_BANK_W];
    assign rowField  = addr[`SDRAM_COL_W +: `SDRAM_ROW_W];
    assign colField  = addr[`SDRAM_COL_W-1:0];
    // A10 high asks for auto-precharge after the burst.
    assign colAddr   = {{(`SDRAM_ROW_W-`SDRAM_COL_W-2){1'b0}}, 1'b1, 1'b0, colField};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmdQ.code <= sdramPkg::CMD_NOP;     // CKE high, NOP.
            sdBa      <= '1;
            sdA       <= '1;
        end else if (cmdValid) begin
            cmdQ.pins <= cmd.pins;
            case (addrSel)
                sdramPkg::SEL_ROW: begin
                    sdBa <= bankField;
                    sdA  <= rowField;
                end
                sdramPkg::SEL_COLUMN: begin
                    sdBa <= bankField;
                    sdA  <= colAddr;
                end
                sdramPkg::SEL_PRECHARGE_ALL: begin
                    sdBa <= '1;
                    sdA  <= '1;             // A10 high hits every bank.
                end
                sdramPkg::SEL_MODE: begin
                    sdBa <= '0;
                    sdA  <= `SDRAM_MODE_WORD;
                end
            endcase
        end else begin
            cmdQ.code <= sdramPkg::CMD_NOP;     // BA and A hold.
        end
    end

    assign sdCke  = cmdQ.pins.cke;
    assign sdCsN  = cmdQ.pins.csN;
    assign sdRasN = cmdQ.pins.rasN;
    assign sdCasN = cmdQ.pins.casN;
    assign sdWeN  = cmdQ.pins.weN;

endmodule

//--- src/sdramPkg.sv
`include "sdramCtrl_cfg.svh"

package sdramPkg;

    // Bank on top, then row, then column.
    typedef logic [`SDRAM_BANK_W+`SDRAM_ROW_W+`SDRAM_COL_W-1:0] sdramAddr_t;
    typedef logic [`SDRAM_DQ_W-1:0] sdramWord_t;

    ////////////////////////////////////////////////////////////////////////
    // Command word as {CKE, CS_N, RAS_N, CAS_N, WE_N}.
    ////////////////////////////////////////////////////////////////////////
    typedef enum logic [4:0] {
        CMD_INIT = 5'b01111,        // Clock disabled, power-on state.
        CMD_NOP  = 5'b10111,        // No operation.
        CMD_ACT  = 5'b10011,        // Open a row.
        CMD_WR   = 5'b10100,        // Write burst.
        CMD_RD   = 5'b10101,        // Read burst.
        CMD_PR   = 5'b10010,        // Precharge.
        CMD_AR   = 5'b10001,        // Auto-refresh.
        CMD_LMR  = 5'b10000         // Load mode register.
    } sdramCmdCode_e;

    typedef struct packed {
        logic cke;
        logic csN;
        logic rasN;
        logic casN;
        logic weN;
    } sdramPins_t;

    // Sequencer writes the code, the pin driver reads the pins.
    typedef union packed {
        sdramCmdCode_e code;
        sdramPins_t    pins;
    } sdramCmd_u;

    typedef enum logic [1:0] {OP_INIT, OP_REFRESH, OP_READ, OP_WRITE} sdramOp_e;

    // What goes out on BA and A with a command.
    typedef enum logic [1:0] {
        SEL_ROW,
        SEL_COLUMN,
        SEL_PRECHARGE_ALL,
        SEL_MODE
    } sdramAddrSel_e;

endpackage
